// ==== bench/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

    typedef struct {
        string                 name;
        logic                  op;
        logic                  uncache;
        logic [31:0]           addr;
        dcache_cfg_pkg::strb_t wstrb;
        dcache_cfg_pkg::word_t wdata;
        dcache_cfg_pkg::word_t exp_rdata;
        int                    exp_fills;
    } row_t;

    logic                        clk;
    logic                        resetn;
    logic                        valid;
    dcache_bus_pkg::cpu_req_t    req;
    logic                        addr_ok;
    logic                        data_ok;
    dcache_cfg_pkg::word_t       rdata;
    dcache_bus_pkg::mem_rd_req_t rd;
    logic                        rd_rdy;
    logic                        ret_valid;
    dcache_cfg_pkg::line_t       ret_data;
    dcache_bus_pkg::mem_wr_req_t wr;
    logic                        wr_rdy;
    logic                        wr_ok;
    int                          line_reads;
    int                          mem_errors;

    row_t                        rows [$];
    logic [31:0]                 ref_mem [logic [31:0]];
    int                          checks = 0;
    int                          failures = 0;
    int                          cycle_count = 0;
    int                          timeout_limit = 100;

    dcache_top #(.SETS(256), .MAX_WRITES(8)) uut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd        (rd),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr        (wr),
        .wr_rdy    (wr_rdy),
        .wr_ok     (wr_ok)
    );

    mem_model bus_mem (
        .clk        (clk),
        .rd         (rd),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .wr         (wr),
        .wr_rdy     (wr_rdy),
        .wr_ok      (wr_ok),
        .line_reads (line_reads),
        .errors     (mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Flat memory view of what every load should see
    function automatic dcache_cfg_pkg::word_t ref_read(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic dcache_cfg_pkg::word_t merge_bytes(input dcache_cfg_pkg::word_t old,
                                                          input dcache_cfg_pkg::strb_t strb,
                                                          input dcache_cfg_pkg::word_t data);
        dcache_cfg_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_row(input string name, input logic op, input logic uncache,
                           input logic [31:0] addr, input dcache_cfg_pkg::strb_t wstrb,
                           input dcache_cfg_pkg::word_t wdata, input int exp_fills);
        row_t r;
        r.name      = name;
        r.op        = op;
        r.uncache   = uncache;
        r.addr      = addr;
        r.wstrb     = wstrb;
        r.wdata     = wdata;
        r.exp_fills = exp_fills;
        r.exp_rdata = ref_read(addr);
        if (op) begin
            ref_mem[{addr[31:2], 2'b00}] = merge_bytes(r.exp_rdata, wstrb, wdata);
        end
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, inout logic test_ok);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            failures++;
            test_ok = 1'b0;
        end
    endtask

    task automatic run_row(input row_t r);
        int                    reads_before;
        logic                  row_ok;
        dcache_cfg_pkg::word_t got;
        reads_before = line_reads;
        row_ok = 1'b1;
        @(negedge clk);
        valid       = 1'b1;
        req.op      = r.op;
        req.uncache = r.uncache;
        req.tag     = r.addr[31:12];
        req.index   = r.addr[11:4];
        req.offset  = r.addr[3:0];
        req.size    = 2'd2;
        req.wstrb   = r.wstrb;
        req.wdata   = r.wdata;
        // Handshakes sampled at the rising edge before the DUT updates
        do @(posedge clk); while (!addr_ok);
        @(negedge clk);
        valid = 1'b0;
        do @(posedge clk); while (!data_ok);
        got = rdata;
        if (!r.op) begin
            check_value(r.name, r.exp_rdata, got, row_ok);
        end
        check_value({r.name, " line reads"}, 32'(r.exp_fills),
                    32'(line_reads - reads_before), row_ok);
        $display("%s: %s", r.name, row_ok ? "ok" : "failed");
    endtask

    initial begin
        logic wb_ok;
        void'($urandom(32'h2be9_149a));
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        add_row("ld_miss",        1'b0, 1'b0, 32'h0001_0104, 4'h0,    32'h0,         1);
        add_row("ld_same_line",   1'b0, 1'b0, 32'h0001_010C, 4'h0,    32'h0,         0);
        add_row("st_hit_partial", 1'b1, 1'b0, 32'h0001_0104, 4'b0110, 32'h1122_3344, 0);
        add_row("ld_merged",      1'b0, 1'b0, 32'h0001_0104, 4'h0,    32'h0,         0);
        // Three tags on set 0x20, two ways
        add_row("st_a",           1'b1, 1'b0, 32'h0002_0204, 4'hF,    32'hDEAD_BEEF, 1);
        add_row("st_b",           1'b1, 1'b0, 32'h0003_0208, 4'b0011, 32'h0000_5A5A, 1);
        add_row("ld_a_warm",      1'b0, 1'b0, 32'h0002_0204, 4'h0,    32'h0,         0);
        add_row("st_c",           1'b1, 1'b0, 32'h0004_020C, 4'b1000, 32'h7700_0000, 1);
        add_row("ld_a",           1'b0, 1'b0, 32'h0002_0204, 4'h0,    32'h0,         0);
        add_row("ld_b",           1'b0, 1'b0, 32'h0003_0208, 4'h0,    32'h0,         1);
        add_row("ld_c",           1'b0, 1'b0, 32'h0004_020C, 4'h0,    32'h0,         1);
        add_row("st_miss",        1'b1, 1'b0, 32'h0005_0304, 4'b1001, 32'hAB00_00CD, 1);
        add_row("ld_alloc",       1'b0, 1'b0, 32'h0005_0304, 4'h0,    32'h0,         0);
        add_row("ld_alloc_other", 1'b0, 1'b0, 32'h0005_0300, 4'h0,    32'h0,         0);
        add_row("uc_write",       1'b1, 1'b1, 32'h0009_0010, 4'hF,    32'h1357_9BDF, 0);
        add_row("uc_read",        1'b0, 1'b1, 32'h0009_0010, 4'h0,    32'h0,         0);
        timeout_limit = 60 * rows.size() + 100;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        // Lines b and c were evicted dirty
        wb_ok = 1'b1;
        check_value("wb_line_b", ref_read(32'h0003_0208), bus_mem.peek(32'h0003_0208), wb_ok);
        check_value("wb_line_c", ref_read(32'h0004_020C), bus_mem.peek(32'h0004_020C), wb_ok);
        $display("write_back: %s", wb_ok ? "ok" : "failed");
        $display("%0d checks, %0d failed, %0d bus model errors", checks, failures, mem_errors);
        if (failures == 0 && mem_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/10ps

module mem_model (
    input  logic                        clk,
    input  dcache_bus_pkg::mem_rd_req_t rd,
    output logic                        rd_rdy,
    output logic                        ret_valid,
    output dcache_cfg_pkg::line_t       ret_data,
    input  dcache_bus_pkg::mem_wr_req_t wr,
    output logic                        wr_rdy,
    output logic                        wr_ok,
    output int                          line_reads,
    output int                          errors
);

    logic [31:0]           words [logic [31:0]];
    int                    ok_due [$];
    int                    cycle;
    int                    rd_wait;
    int                    wr_wait;
    logic                  reply_due;
    dcache_cfg_pkg::line_t reply;

    // Untouched words hold their own address pattern
    function automatic logic [31:0] peek(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old,
                                                  input logic [3:0] strb,
                                                  input logic [31:0] data);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic take_read();
        logic [31:0] base;
        base = {rd.addr[31:2], 2'b00};
        reply = '0;
        if (rd.line) begin
            base[3:2] = 2'b00;
            for (int w = 0; w < 4; w++) begin
                reply[w*32 +: 32] = peek(base + 32'(4 * w));
            end
            line_reads++;
        end else begin
            assert (ok_due.size() == 0) else begin
                $display("Uncached read of %h issued while %0d bus writes still wait for wr_ok",
                         rd.addr, ok_due.size());
                errors++;
            end
            reply[31:0] = peek(base);
        end
        reply_due = 1'b1;
    endtask

    task automatic take_write();
        logic [31:0] base;
        base = {wr.addr[31:2], 2'b00};
        if (wr.line) begin
            for (int w = 0; w < 4; w++) begin
                words[{base[31:4], 4'h0} + 32'(4 * w)] = wr.data[w*32 +: 32];
            end
        end else begin
            words[base] = apply_strobes(peek(base), wr.wstrb, wr.data[31:0]);
        end
        ok_due.push_back(cycle + int'($urandom_range(6, 1)));
    endtask

    initial begin
        rd_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_data   = '0;
        wr_rdy     = 1'b0;
        wr_ok      = 1'b0;
        line_reads = 0;
        errors     = 0;
        cycle      = 0;
        rd_wait    = 0;
        wr_wait    = 0;
        reply_due  = 1'b0;
    end

    // Decisions here take effect at the next rising edge
    always @(negedge clk) begin
        cycle++;
        ret_valid = 1'b0;
        wr_ok     = 1'b0;
        if (reply_due) begin
            ret_valid = 1'b1;
            ret_data  = reply;
            reply_due = 1'b0;
        end
        rd_rdy = 1'b0;
        if (rd.req) begin
            if (rd_wait > 0) begin
                rd_wait--;
            end else begin
                rd_rdy = 1'b1;
                take_read();
                rd_wait = $urandom_range(3);
            end
        end
        wr_rdy = 1'b0;
        if (wr.req) begin
            if (wr_wait > 0) begin
                wr_wait--;
            end else begin
                wr_rdy = 1'b1;
                take_write();
                wr_wait = $urandom_range(3);
            end
        end
        // Acks leave in order
        if (ok_due.size() > 0 && cycle >= ok_due[0]) begin
            wr_ok = 1'b1;
            void'(ok_due.pop_front());
        end
    end

endmodule

// ==== dcache.f ====
source/dcache_cfg_pkg.sv
source/dcache_bus_pkg.sv
source/sync_ram.sv
source/write_credit_counter.sv
source/tag_compare_replace.sv
source/line_merge.sv
source/dcache_ctrl.sv
source/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

// ==== source/dcache_bus_pkg.sv ====
package dcache_bus_pkg;

    // CPU request, op 0 is a load and 1 a store
    typedef struct packed {
        logic                    op;
        logic                    uncache;
        dcache_cfg_pkg::tag_t    tag;
        dcache_cfg_pkg::index_t  index;
        dcache_cfg_pkg::offset_t offset;
        logic [1:0]              size;
        dcache_cfg_pkg::strb_t   wstrb;
        dcache_cfg_pkg::word_t   wdata;
    } cpu_req_t;

    // Bus read, line 1 asks for a whole line
    typedef struct packed {
        logic        req;
        logic        line;
        logic [31:0] addr;
        logic [2:0]  size;
    } mem_rd_req_t;

    // Bus write, a single word sits in the low bits of data
    typedef struct packed {
        logic                  req;
        logic                  line;
        logic [31:0]           addr;
        logic [2:0]            size;
        dcache_cfg_pkg::strb_t wstrb;
        dcache_cfg_pkg::line_t data;
    } mem_wr_req_t;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        STORE,
        MISS,
        REPLACE,
        REFILL,
        URREQ,
        URRESP,
        UWREQ
    } ctrl_state_t;

endpackage

// ==== source/dcache_cfg_pkg.sv ====
package dcache_cfg_pkg;

    // Address split is tag, index, byte offset
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;

    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;

    // One strobe bit per byte of a word
    typedef logic [WORD_W/8-1:0] strb_t;

endpackage

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          valid,
    input  dcache_bus_pkg::cpu_req_t      req,
    input  logic                          hit,
    input  logic                          victim_dirty,
    input  dcache_cfg_pkg::tag_t          victim_tag,
    input  dcache_cfg_pkg::line_t         victim_line,
    input  logic                          ret_valid,
    input  logic                          rd_rdy,
    input  logic                          wr_rdy,
    input  logic                          writes_idle,
    input  logic                          writes_full,
    input  dcache_cfg_pkg::word_t         load_word,
    input  dcache_cfg_pkg::word_t         refill_word,
    input  dcache_cfg_pkg::line_t         ret_data,
    output dcache_bus_pkg::cpu_req_t      held_req,
    output logic                          ram_rd,
    output logic                          lookup,
    output logic                          store_we,
    output logic                          refill_we,
    output logic                          addr_ok,
    output logic                          data_ok,
    output dcache_cfg_pkg::word_t         rdata,
    output dcache_bus_pkg::mem_rd_req_t   rd,
    output dcache_bus_pkg::mem_wr_req_t   wr
);

    dcache_bus_pkg::ctrl_state_t state;
    dcache_bus_pkg::ctrl_state_t next_state;
    logic                        accept;
    logic [31:0]                 word_addr;
    logic [31:0]                 line_addr;

    assign addr_ok   = (state == dcache_bus_pkg::IDLE) && valid;
    assign accept    = valid && addr_ok;
    assign ram_rd    = accept && !req.uncache;
    assign lookup    = (state == dcache_bus_pkg::LOOKUP);
    assign store_we  = (state == dcache_bus_pkg::STORE);
    assign refill_we = (state == dcache_bus_pkg::REFILL) && ret_valid;

    assign word_addr = {held_req.tag, held_req.index, held_req.offset};
    assign line_addr = {held_req.tag, held_req.index, dcache_cfg_pkg::offset_t'(0)};

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= dcache_bus_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_bus_pkg::IDLE: begin
                if (accept && !req.uncache) begin
                    next_state = dcache_bus_pkg::LOOKUP;
                end else if (accept) begin
                    next_state = req.op ? dcache_bus_pkg::UWREQ : dcache_bus_pkg::URREQ;
                end
            end
            dcache_bus_pkg::LOOKUP: begin
                if (!hit) begin
                    next_state = dcache_bus_pkg::MISS;
                end else begin
                    next_state = held_req.op ? dcache_bus_pkg::STORE : dcache_bus_pkg::IDLE;
                end
            end
            dcache_bus_pkg::STORE:   next_state = dcache_bus_pkg::IDLE;
            // Clean victims skip straight to the line read
            dcache_bus_pkg::MISS: begin
                if (!victim_dirty || (wr.req && wr_rdy)) begin
                    next_state = dcache_bus_pkg::REPLACE;
                end
            end
            dcache_bus_pkg::REPLACE: if (rd_rdy) next_state = dcache_bus_pkg::REFILL;
            dcache_bus_pkg::REFILL:  if (ret_valid) next_state = dcache_bus_pkg::IDLE;
            dcache_bus_pkg::URREQ:   if (rd.req && rd_rdy) next_state = dcache_bus_pkg::URRESP;
            dcache_bus_pkg::URRESP:  if (ret_valid) next_state = dcache_bus_pkg::IDLE;
            dcache_bus_pkg::UWREQ:   if (wr.req && wr_rdy) next_state = dcache_bus_pkg::IDLE;
            default:                 next_state = dcache_bus_pkg::IDLE;
        endcase
    end

    always_comb begin
        rd.line = (state == dcache_bus_pkg::REPLACE);
        // Uncached reads wait behind every outstanding write
        rd.req  = rd.line || ((state == dcache_bus_pkg::URREQ) && writes_idle);
        rd.addr = rd.line ? line_addr : word_addr;
        rd.size = rd.line ? 3'd2 : {1'b0, held_req.size};

        wr.line  = (state == dcache_bus_pkg::MISS);
        wr.req   = ((wr.line && victim_dirty) || (state == dcache_bus_pkg::UWREQ)) && !writes_full;
        wr.addr  = wr.line ? {victim_tag, held_req.index, dcache_cfg_pkg::offset_t'(0)} : word_addr;
        wr.size  = wr.line ? 3'd2 : {1'b0, held_req.size};
        wr.wstrb = wr.line ? '1 : held_req.wstrb;
        wr.data  = wr.line ? victim_line : dcache_cfg_pkg::line_t'(held_req.wdata);
    end

    assign data_ok = (lookup && hit) || refill_we ||
                     ((state == dcache_bus_pkg::URRESP) && ret_valid) ||
                     ((state == dcache_bus_pkg::UWREQ) && wr.req && wr_rdy);

    always_comb begin
        rdata = ret_data[dcache_cfg_pkg::WORD_W-1:0];
        if (lookup) begin
            rdata = load_word;
        end else if (state == dcache_bus_pkg::REFILL) begin
            rdata = refill_word;
        end
    end

    // No new acceptance before the request in flight ends
    a_one_in_flight: assert property (@(posedge clk) disable iff (!resetn)
        accept |=> !addr_ok until_with data_ok);

    a_rd_held: assert property (@(posedge clk) disable iff (!resetn)
        rd.req && !rd_rdy |=> rd.req && $stable(rd.addr));

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top #(
    parameter int SETS       = 256,
    parameter int MAX_WRITES = 8
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  dcache_bus_pkg::cpu_req_t    req,
    output logic                        addr_ok,
    output logic                        data_ok,
    output dcache_cfg_pkg::word_t       rdata,
    output dcache_bus_pkg::mem_rd_req_t rd,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  dcache_cfg_pkg::line_t       ret_data,
    output dcache_bus_pkg::mem_wr_req_t wr,
    input  logic                        wr_rdy,
    input  logic                        wr_ok
);

    dcache_bus_pkg::cpu_req_t    held_req;
    logic                        ram_rd;
    logic                        lookup;
    logic                        store_we;
    logic                        refill_we;
    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;
    dcache_cfg_pkg::tag_t        victim_tag;
    logic                        writes_idle;
    logic                        writes_full;
    dcache_cfg_pkg::word_t       load_word;
    dcache_cfg_pkg::word_t       refill_word;
    dcache_cfg_pkg::line_t       store_line;
    dcache_cfg_pkg::line_t       refill_line;
    dcache_cfg_pkg::line_t       victim_line;
    dcache_cfg_pkg::index_t      ram_addr;
    dcache_cfg_pkg::line_t       line_din;
    dcache_cfg_pkg::tag_t  [1:0] way_tag;
    dcache_cfg_pkg::line_t [1:0] way_line;
    logic                  [1:0] tag_we;
    logic                  [1:0] line_we;

    // New index on acceptance, held index for later writes
    assign ram_addr = ram_rd ? req.index : held_req.index;
    assign line_din = store_we ? store_line : refill_line;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign tag_we[w]  = refill_we && (victim_way == 1'(w));
        assign line_we[w] = tag_we[w] || (store_we && (hit_way == 1'(w)));

        sync_ram #(.entry_t(dcache_cfg_pkg::tag_t), .DEPTH(SETS)) u_tag_ram (
            .clk  (clk),
            .en   (ram_rd || tag_we[w]),
            .we   (tag_we[w]),
            .addr (ram_addr),
            .din  (held_req.tag),
            .dout (way_tag[w])
        );

        sync_ram #(.entry_t(dcache_cfg_pkg::line_t), .DEPTH(SETS)) u_line_ram (
            .clk  (clk),
            .en   (ram_rd || line_we[w]),
            .we   (line_we[w]),
            .addr (ram_addr),
            .din  (line_din),
            .dout (way_line[w])
        );
    end

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .ret_valid    (ret_valid),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .writes_idle  (writes_idle),
        .writes_full  (writes_full),
        .load_word    (load_word),
        .refill_word  (refill_word),
        .ret_data     (ret_data),
        .held_req     (held_req),
        .ram_rd       (ram_rd),
        .lookup       (lookup),
        .store_we     (store_we),
        .refill_we    (refill_we),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd           (rd),
        .wr           (wr)
    );

    write_credit_counter #(.MAX_WRITES(MAX_WRITES)) u_credit (
        .clk         (clk),
        .resetn      (resetn),
        .wr_accept   (wr.req && wr_rdy),
        .wr_ok       (wr_ok),
        .writes_idle (writes_idle),
        .writes_full (writes_full)
    );

    tag_compare_replace #(.SETS(SETS)) u_tag (
        .clk          (clk),
        .resetn       (resetn),
        .held_req     (held_req),
        .way_tag      (way_tag),
        .lookup       (lookup),
        .store_we     (store_we),
        .refill_we    (refill_we),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    line_merge u_merge (
        .clk         (clk),
        .held_req    (held_req),
        .way_line    (way_line),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .lookup      (lookup),
        .ret_data    (ret_data),
        .load_word   (load_word),
        .refill_word (refill_word),
        .store_line  (store_line),
        .refill_line (refill_line),
        .victim_line (victim_line)
    );

endmodule

// ==== source/line_merge.sv ====
`timescale 1ns/10ps

module line_merge (
    input  logic                        clk,
    input  dcache_bus_pkg::cpu_req_t    held_req,
    input  dcache_cfg_pkg::line_t [1:0] way_line,
    input  logic                        hit,
    input  logic                        hit_way,
    input  logic                        victim_way,
    input  logic                        lookup,
    input  dcache_cfg_pkg::line_t       ret_data,
    output dcache_cfg_pkg::word_t       load_word,
    output dcache_cfg_pkg::word_t       refill_word,
    output dcache_cfg_pkg::line_t       store_line,
    output dcache_cfg_pkg::line_t       refill_line,
    output dcache_cfg_pkg::line_t       victim_line
);

    localparam int WORD_W = dcache_cfg_pkg::WORD_W;

    dcache_cfg_pkg::line_t line_q;
    logic [1:0]            word_sel;

    // Writes the store bytes over the addressed word of a line
    function automatic dcache_cfg_pkg::line_t merge(dcache_cfg_pkg::line_t base,
                                                    dcache_bus_pkg::cpu_req_t r);
        dcache_cfg_pkg::line_t res;
        int                    pos;
        res = base;
        for (int b = 0; b < WORD_W / 8; b++) begin
            pos = r.offset[dcache_cfg_pkg::OFFSET_W-1:2] * WORD_W + b * 8;
            if (r.wstrb[b]) begin
                res[pos +: 8] = r.wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign word_sel = held_req.offset[dcache_cfg_pkg::OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (lookup) begin
            line_q <= way_line[hit ? hit_way : victim_way];
        end
    end

    assign load_word   = way_line[hit_way][word_sel*WORD_W +: WORD_W];
    assign refill_word = ret_data[word_sel*WORD_W +: WORD_W];
    assign store_line  = merge(line_q, held_req);
    assign refill_line = held_req.op ? merge(ret_data, held_req) : ret_data;
    assign victim_line = line_q;

endmodule

// ==== source/sync_ram.sv ====
`timescale 1ns/10ps

module sync_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  dcache_cfg_pkg::index_t addr,
    input  entry_t                 din,
    output entry_t                 dout
);

    entry_t mem [DEPTH];

    // Read-first, dout keeps the old entry on a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

// ==== source/tag_compare_replace.sv ====
`timescale 1ns/10ps

module tag_compare_replace #(
    parameter int SETS = 256
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  dcache_bus_pkg::cpu_req_t       held_req,
    input  dcache_cfg_pkg::tag_t [1:0]     way_tag,
    input  logic                           lookup,
    input  logic                           store_we,
    input  logic                           refill_we,
    output logic                           hit,
    output logic                           hit_way,
    output logic                           victim_way,
    output logic                           victim_dirty,
    output dcache_cfg_pkg::tag_t           victim_tag
);

    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      last_hit_q;
    logic [1:0]           way_hit;
    logic [1:0]           way_v;
    logic [1:0]           way_d;
    logic                 pick;
    logic                 victim_q;

    for (genvar w = 0; w < 2; w++) begin : g_cmp
        assign way_v[w]   = valid_q[w][held_req.index];
        assign way_d[w]   = way_v[w] && dirty_q[w][held_req.index];
        assign way_hit[w] = way_v[w] && (way_tag[w] == held_req.tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Invalid first, then clean over dirty, then not last hit
    always_comb begin
        if (!way_v[0]) begin
            pick = 1'b0;
        end else if (!way_v[1]) begin
            pick = 1'b1;
        end else if (way_d[0] != way_d[1]) begin
            pick = way_d[0];
        end else begin
            pick = !last_hit_q[held_req.index];
        end
    end

    assign victim_way = lookup ? pick : victim_q;

    always_ff @(posedge clk) begin
        if (lookup && !hit) begin
            victim_q     <= pick;
            victim_dirty <= way_d[pick];
            victim_tag   <= way_tag[pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            last_hit_q <= '0;
        end else begin
            if (lookup && hit) begin
                last_hit_q[held_req.index] <= hit_way;
            end
            if (store_we) begin
                dirty_q[hit_way][held_req.index] <= 1'b1;
            end
            if (refill_we) begin
                valid_q[victim_q][held_req.index] <= 1'b1;
                dirty_q[victim_q][held_req.index] <= held_req.op;
            end
        end
    end

    // Refill only ever fills a way that missed
    a_one_hit: assert property (@(posedge clk) disable iff (!resetn)
        lookup |-> !(&way_hit));

endmodule

// ==== source/write_credit_counter.sv ====
`timescale 1ns/10ps

module write_credit_counter #(
    parameter int MAX_WRITES = 8
) (
    input  logic clk,
    input  logic resetn,
    input  logic wr_accept,
    input  logic wr_ok,
    output logic writes_idle,
    output logic writes_full
);

    localparam int CNT_W = $clog2(MAX_WRITES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (wr_accept && !wr_ok) begin
            count <= count + 1'b1;
        end else if (wr_ok && !wr_accept) begin
            count <= count - 1'b1;
        end
    end

    assign writes_idle = (count == '0);
    assign writes_full = (count == CNT_W'(MAX_WRITES));

    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        wr_accept |-> !writes_full);

    // Bus may only acknowledge writes it has taken
    a_no_stray_ok: assert property (@(posedge clk) disable iff (!resetn)
        wr_ok |-> !writes_idle);

endmodule
